//--- sources.f
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/cpu_ifs.sv
verilog/instr_decode.sv
verilog/sequencer.sv
verilog/datapath.sv
verilog/addr_unit.sv
verilog/srm_cpu.sv
verification/tb_clock.sv
verification/tb_memory.sv
verification/tb_srm_cpu.sv

//--- Bender.yml
package:
  name: srm_cpu

sources:
  - files:
      - verilog/isa_pkg.sv
      - verilog/ctrl_pkg.sv
      - verilog/cpu_ifs.sv
      - verilog/instr_decode.sv
      - verilog/sequencer.sv
      - verilog/datapath.sv
      - verilog/addr_unit.sv
      - verilog/srm_cpu.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tb_memory.sv
      - verification/tb_srm_cpu.sv

//--- verification/tb_srm_cpu.sv
// Testbench top with LFSR, check task, program loading, directed tests and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_srm_cpu;
   import isa_pkg::*;
   import ctrl_pkg::*;

   localparam int         CLK_PERIOD = 10;
   localparam int         MARGIN     = 20;
   // Negative imm8 bases land in the upper half of the 512-word memory
   localparam logic [7:0] DATA_IMM   = 8'h80;
   localparam logic [7:0] RES_IMM    = 8'hA0;
   localparam logic [7:0] LOAD_IMM   = 8'hC0;
   localparam logic [7:0] COPY_IMM   = 8'hE0;
   localparam word_t      HALT_WORD  = 16'hE000;

   logic      clk;
   logic      reset;
   mem_cmd_t  mem_cmd;
   mem_addr_t mem_addr;
   word_t     read_data;
   word_t     write_data;
   logic      halt;

   logic [31:0] lfsr = 32'hd3a1;
   word_t       prog [$];
   int unsigned check_count = 0;
   int unsigned budget = 0;
   int unsigned run_cycles = 0;
   int unsigned halt_cycle = 0;
   logic        watch_on = 1'b0;

   tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) i_clock (.clk(clk), .reset(reset));

   tb_memory i_mem (
      .clk        (clk),
      .mem_cmd    (mem_cmd),
      .mem_addr   (mem_addr),
      .write_data (write_data),
      .read_data  (read_data)
   );

   srm_cpu i_dut (
      .clk        (clk),
      .reset      (reset),
      .mem_cmd    (mem_cmd),
      .mem_addr   (mem_addr),
      .read_data  (read_data),
      .write_data (write_data),
      .halt       (halt)
   );

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic word_t random_word();
      word_t w;
      for (int i = 0; i < 16; i++) begin
         lfsr = lfsr_step(lfsr);
         w    = {w[14:0], lfsr[0]};
      end
      return w;
   endfunction

   function automatic word_t sext8(input logic [7:0] imm);
      return {{8{imm[7]}}, imm};
   endfunction

   function automatic word_t shifted(input word_t v, input shift_t sh);
      case (sh)
         SH_LEFT:          return v << 1;
         SH_RIGHT_LOGICAL: return v >> 1;
         SH_RIGHT_ARITH:   return word_t'($signed(v) >>> 1);
         default:          return v;
      endcase
   endfunction

   function automatic int data_address(input word_t base, input logic [4:0] imm5);
      word_t sum;
      sum = base + {{11{imm5[4]}}, imm5};
      return int'(sum[8:0]);
   endfunction

   function automatic logic branch_taken(input cond_t c, input word_t x, input word_t y);
      case (c)
         COND_EQ: return x == y;
         COND_NE: return x != y;
         COND_LT: return $signed(x) < $signed(y);
         COND_LE: return $signed(x) <= $signed(y);
         default: return 1'b1;
      endcase
   endfunction

   function automatic word_t reg_instr(input opcode_t opc, input logic [1:0] op,
         input reg_idx_t rn, input reg_idx_t rd, input shift_t sh, input reg_idx_t rm);
      return {opc, op, rn, rd, sh, rm};
   endfunction

   function automatic word_t imm_instr(input opcode_t opc, input logic [1:0] op,
         input logic [2:0] rn, input logic [7:0] imm8);
      return {opc, op, rn, imm8};
   endfunction

   function automatic word_t mem_instr(input opcode_t opc, input reg_idx_t rn,
         input reg_idx_t rd, input logic [4:0] imm5);
      return {opc, 2'b00, rn, rd, imm5};
   endfunction

   task automatic check_equal(input string test, input string what,
         input logic [31:0] expected, input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         $display("Error in %s: %s expected 0x%0h, actual 0x%0h", test, what, expected, actual);
         $display("Verification failed");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // 5 cycles per instruction plus margin for each program
   always @(posedge clk) begin
      if (watch_on) begin
         run_cycles = run_cycles + 1;
         if (run_cycles > budget) begin
            $display("Timeout: the DUT did not raise halt within %0d cycles", budget);
            $display("Verification failed");
            $fatal(1, "Watchdog expired");
         end
      end
   end

   // Program goes to address 0; halt_cycle counts the release cycle as 1
   task automatic run_program(input string test);
      i_clock.start_reset();
      for (int a = 0; a < prog.size(); a++) begin
         i_mem.load_word(a, prog[a]);
      end
      i_clock.end_reset();
      check_equal(test, "halt after reset", 0, halt);
      budget     = 5 * prog.size() + MARGIN;
      run_cycles = 0;
      halt_cycle = 1;
      watch_on   = 1'b1;
      while (halt !== 1'b1) begin
         @(posedge clk);
         #1;
         halt_cycle++;
      end
      watch_on = 1'b0;
   endtask

   task automatic mov_shift_test();
      word_t v [2];
      word_t imm;
      word_t exp_val [$];
      v[0] = random_word();
      v[1] = random_word() | 16'h8000;
      imm  = random_word();
      i_mem.clear();
      i_mem.load_word(data_address(sext8(DATA_IMM), 0), v[0]);
      i_mem.load_word(data_address(sext8(DATA_IMM), 1), v[1]);
      prog.delete();
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 7, DATA_IMM));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 6, RES_IMM));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 1, imm[7:0]));
      prog.push_back(mem_instr(OPC_STORE, 6, 1, 0));
      exp_val.push_back(sext8(imm[7:0]));
      for (int k = 0; k < 2; k++) begin
         prog.push_back(mem_instr(OPC_LOAD, 7, 0, k));
         for (int s = 0; s < 4; s++) begin
            prog.push_back(reg_instr(OPC_MOVE, 2'b00, 0, 2, shift_t'(s), 0));
            prog.push_back(mem_instr(OPC_STORE, 6, 2, exp_val.size()));
            exp_val.push_back(shifted(v[k], shift_t'(s)));
         end
         prog.push_back(reg_instr(OPC_ALU, ALU_MVN, 0, 3, shift_t'(k), 0));
         prog.push_back(mem_instr(OPC_STORE, 6, 3, exp_val.size()));
         exp_val.push_back(~shifted(v[k], shift_t'(k)));
      end
      prog.push_back(HALT_WORD);
      run_program("mov_shift");
      for (int i = 0; i < exp_val.size(); i++) begin
         check_equal("mov_shift", $sformatf("result word %0d", i), exp_val[i],
                     i_mem.mem[data_address(sext8(RES_IMM), i)]);
      end
   endtask

   task automatic add_and_test();
      word_t a;
      word_t b;
      word_t exp_val [$];
      i_mem.clear();
      prog.delete();
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 7, DATA_IMM));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 6, RES_IMM));
      for (int k = 0; k < 3; k++) begin
         a = random_word();
         b = (k == 0) ? 16'hFFFF : random_word();
         i_mem.load_word(data_address(sext8(DATA_IMM), 2 * k), a);
         i_mem.load_word(data_address(sext8(DATA_IMM), 2 * k + 1), b);
         prog.push_back(mem_instr(OPC_LOAD, 7, 0, 2 * k));
         prog.push_back(mem_instr(OPC_LOAD, 7, 1, 2 * k + 1));
         prog.push_back(reg_instr(OPC_ALU, ALU_ADD, 0, 2, SH_NONE, 1));
         prog.push_back(mem_instr(OPC_STORE, 6, 2, 3 * k));
         prog.push_back(reg_instr(OPC_ALU, ALU_AND, 0, 3, SH_NONE, 1));
         prog.push_back(mem_instr(OPC_STORE, 6, 3, 3 * k + 1));
         prog.push_back(reg_instr(OPC_ALU, ALU_ADD, 0, 4, SH_RIGHT_ARITH, 1));
         prog.push_back(mem_instr(OPC_STORE, 6, 4, 3 * k + 2));
         exp_val.push_back(a + b);
         exp_val.push_back(a & b);
         exp_val.push_back(a + shifted(b, SH_RIGHT_ARITH));
      end
      prog.push_back(HALT_WORD);
      run_program("add_and");
      for (int i = 0; i < exp_val.size(); i++) begin
         check_equal("add_and", $sformatf("result word %0d", i), exp_val[i],
                     i_mem.mem[data_address(sext8(RES_IMM), i)]);
      end
   endtask

   task automatic load_store_test();
      logic [4:0] loff [4] = '{5'd3, 5'd15, 5'h1F, 5'h10};
      logic [4:0] soff [4] = '{5'h18, 5'd0, 5'd7, 5'h10};
      word_t      d [4];
      i_mem.clear();
      prog.delete();
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 5, LOAD_IMM));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 4, COPY_IMM));
      for (int i = 0; i < 4; i++) begin
         d[i] = random_word();
         i_mem.load_word(data_address(sext8(LOAD_IMM), loff[i]), d[i]);
         prog.push_back(mem_instr(OPC_LOAD, 5, 1, loff[i]));
         prog.push_back(mem_instr(OPC_STORE, 4, 1, soff[i]));
      end
      prog.push_back(HALT_WORD);
      run_program("load_store");
      for (int i = 0; i < 4; i++) begin
         check_equal("load_store", $sformatf("copy %0d", i), d[i],
                     i_mem.mem[data_address(sext8(COPY_IMM), soff[i])]);
      end
   endtask

   // Each block stores the taken or the not-taken marker into its own slot
   task automatic branch_test();
      word_t lo;
      word_t hi;
      word_t x;
      word_t y;
      int    slot;
      lo = (random_word() & 16'hBFFF) | 16'h8000;
      hi = (random_word() | 16'h4000) & 16'h7FFF;
      i_mem.clear();
      i_mem.load_word(data_address(sext8(DATA_IMM), 0), lo);
      i_mem.load_word(data_address(sext8(DATA_IMM), 1), hi);
      prog.delete();
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 7, DATA_IMM));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 6, RES_IMM));
      prog.push_back(mem_instr(OPC_LOAD, 7, 0, 0));
      prog.push_back(mem_instr(OPC_LOAD, 7, 1, 1));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 3, 8'h5A));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 4, 8'hA5));
      for (int c = 0; c < 3; c++) begin
         for (int k = 0; k < 5; k++) begin
            slot = 5 * c + k;
            prog.push_back(reg_instr(OPC_ALU, ALU_CMP, c == 2, 0, SH_NONE, c == 1));
            prog.push_back(imm_instr(OPC_BRANCH, 2'b00, k, 8'd2));
            prog.push_back(mem_instr(OPC_STORE, 6, 3, slot));
            prog.push_back(imm_instr(OPC_BRANCH, 2'b00, COND_AL, 8'd1));
            prog.push_back(mem_instr(OPC_STORE, 6, 4, slot));
         end
      end
      prog.push_back(HALT_WORD);
      run_program("branch");
      for (int c = 0; c < 3; c++) begin
         x = (c == 2) ? hi : lo;
         y = (c == 1) ? hi : lo;
         for (int k = 0; k < 5; k++) begin
            check_equal("branch", $sformatf("case %0d cond %0d", c, k),
                        branch_taken(cond_t'(k), x, y) ? sext8(8'hA5) : sext8(8'h5A),
                        i_mem.mem[data_address(sext8(RES_IMM), 5 * c + k)]);
         end
      end
   endtask

   task automatic halt_test(input string test, input word_t stop_word);
      int unsigned writes;
      int          res;
      res = data_address(sext8(RES_IMM), 0);
      i_mem.clear();
      prog.delete();
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 6, RES_IMM));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 1, 8'h33));
      prog.push_back(mem_instr(OPC_STORE, 6, 1, 0));
      prog.push_back(stop_word);
      prog.push_back(mem_instr(OPC_STORE, 6, 1, 1));
      prog.push_back(HALT_WORD);
      run_program(test);
      writes = i_mem.write_count;
      repeat (20) begin
         @(posedge clk);
         #1;
         check_equal(test, "halt held", 1, halt);
      end
      check_equal(test, "writes after halt", writes, i_mem.write_count);
      check_equal(test, "store before halt", 16'h0033, i_mem.mem[res]);
      check_equal(test, "store after halt", i_mem.fill_value(res + 1), i_mem.mem[res + 1]);
   endtask

   task automatic halt_timing_test();
      int n;
      prog.delete();
      i_mem.clear();
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 0, 8'd5));
      prog.push_back(imm_instr(OPC_MOVE, 2'b10, 1, 8'hFD));
      prog.push_back(reg_instr(OPC_ALU, ALU_ADD, 0, 2, SH_NONE, 1));
      prog.push_back(reg_instr(OPC_ALU, ALU_AND, 0, 3, SH_LEFT, 1));
      prog.push_back(reg_instr(OPC_MOVE, 2'b00, 0, 4, SH_LEFT, 2));
      prog.push_back(reg_instr(OPC_ALU, ALU_CMP, 0, 0, SH_NONE, 1));
      prog.push_back(reg_instr(OPC_ALU, ALU_MVN, 0, 5, SH_NONE, 4));
      n = prog.size();
      prog.push_back(HALT_WORD);
      run_program("halt_timing");
      // One ST_RESET cycle, then 4 cycles for each instruction including HALT
      check_equal("halt_timing", "cycle of halt", 1 + 4 * (n + 1), halt_cycle);
   endtask

   initial begin
      mov_shift_test();
      add_and_test();
      load_store_test();
      branch_test();
      halt_test("halt", HALT_WORD);
      halt_test("opcode_010", 16'h4000);
      halt_timing_test();
      if (check_count > 0) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("No checks were executed");
         $display("Verification failed");
         $fatal(1, "Empty run");
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_memory.sv
// Word-addressed memory model with combinational read and clocked write
`timescale 1ns/1ps
`default_nettype none

module tb_memory (
   input  logic               clk,
   input  ctrl_pkg::mem_cmd_t mem_cmd,
   input  isa_pkg::mem_addr_t mem_addr,
   input  isa_pkg::word_t     write_data,
   output isa_pkg::word_t     read_data
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   localparam int DEPTH = 512;

   word_t       mem [DEPTH];
   int unsigned write_count = 0;

   assign read_data = mem[mem_addr];

   always @(posedge clk) begin
      if (mem_cmd == MEM_WRITE) begin
         mem[mem_addr] <= write_data;
         write_count   <= write_count + 1;
      end
   end

   // HALT opcode in the top bits, full address below
   function automatic word_t fill_value(input int addr);
      return {7'b1110000, addr[8:0]};
   endfunction

   task automatic clear();
      for (int a = 0; a < DEPTH; a++) begin
         mem[a] = fill_value(a);
      end
   endtask

   task automatic load_word(input int addr, input word_t value);
      mem[addr] = value;
   endtask

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
// Testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic reset
);
   initial begin
      clk   = 1'b0;
      reset = 1'b1;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset moves 1 ns after a rising edge like all other stimulus
   task automatic start_reset();
      @(posedge clk);
      #1 reset = 1'b1;
   endtask

   task automatic end_reset();
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
   endtask

endmodule

`default_nettype wire

//--- verilog/srm_cpu.sv
// Processor top level joining decoder, sequencer, datapath and address unit
`timescale 1ns/1ps
`default_nettype none

module srm_cpu (
   input  logic               clk,
   input  logic               reset,
   output ctrl_pkg::mem_cmd_t mem_cmd,
   output isa_pkg::mem_addr_t mem_addr,
   input  isa_pkg::word_t     read_data,
   output isa_pkg::word_t     write_data,
   output logic               halt
);
   import isa_pkg::*;

   decoded_instr_t instr;
   status_t        status;
   logic           load_ir;

   dp_ctrl_if   dp_ctrl ();
   addr_ctrl_if addr_ctrl ();

   instr_decode i_decode (
      .clk       (clk),
      .load_ir   (load_ir),
      .read_data (read_data),
      .instr     (instr)
   );

   sequencer i_seq (
      .clk     (clk),
      .reset   (reset),
      .instr   (instr),
      .status  (status),
      .dp      (dp_ctrl.ctrl),
      .ac      (addr_ctrl.ctrl),
      .load_ir (load_ir),
      .mem_cmd (mem_cmd),
      .halt    (halt)
   );

   // The ALU result is both the store data and the data address
   datapath i_dp (
      .clk    (clk),
      .ctrl   (dp_ctrl.dp),
      .instr  (instr),
      .mdata  (read_data),
      .result (write_data),
      .status (status)
   );

   addr_unit i_addr (
      .clk          (clk),
      .ctrl         (addr_ctrl.addr),
      .sximm8       (instr.sximm8),
      .data_addr_in (write_data),
      .mem_addr     (mem_addr)
   );

endmodule

`default_nettype wire

//--- verilog/addr_unit.sv
// PC with next-PC logic, data address register and memory address mux
`timescale 1ns/1ps
`default_nettype none

module addr_unit (
   input  logic               clk,
   addr_ctrl_if.addr          ctrl,
   input  isa_pkg::word_t     sximm8,
   input  isa_pkg::word_t     data_addr_in,
   output isa_pkg::mem_addr_t mem_addr
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   mem_addr_t pc;
   mem_addr_t next_pc;
   mem_addr_t data_addr;

   // Branch offset is relative to the already incremented PC
   always_comb begin
      unique case (ctrl.pc_sel)
         PC_ZERO:   next_pc = '0;
         PC_BRANCH: next_pc = pc + sximm8[MEM_ADDR_W-1:0];
         default:   next_pc = pc + mem_addr_t'(1);
      endcase
   end

   always_ff @(posedge clk) begin
      if (ctrl.load_pc) begin
         pc <= next_pc;
      end
      if (ctrl.load_addr) begin
         data_addr <= data_addr_in[MEM_ADDR_W-1:0];
      end
   end

   assign mem_addr = ctrl.addr_from_pc ? pc : data_addr;

   a_zero_with_load: assert property (@(posedge clk) (ctrl.pc_sel == PC_ZERO) |-> ctrl.load_pc);

endmodule

`default_nettype wire

//--- verilog/datapath.sv
// Register file, shifter, ALU, operand muxes and status register
`timescale 1ns/1ps
`default_nettype none

module datapath (
   input  logic                    clk,
   dp_ctrl_if.dp                   ctrl,
   input  isa_pkg::decoded_instr_t instr,
   input  isa_pkg::word_t          mdata,
   output isa_pkg::word_t          result,
   output isa_pkg::status_t        status
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   word_t regs [NUM_REGS];
   word_t a_q;
   word_t b_q;
   word_t b_shift;
   word_t ain;
   word_t bin;
   word_t alu_out;
   word_t wb_data;
   logic  ovf;

   always_comb begin
      unique case (ctrl.wb_sel)
         WB_IMM8:  wb_data = instr.sximm8;
         WB_MDATA: wb_data = mdata;
         default:  wb_data = alu_out;
      endcase
   end

   always_ff @(posedge clk) begin
      if (ctrl.write) begin
         regs[ctrl.write_num] <= wb_data;
      end
   end

   // Operands are sampled every cycle from the read ports
   always_ff @(posedge clk) begin
      a_q <= regs[ctrl.read_a];
      b_q <= regs[ctrl.read_b];
   end

   always_comb begin
      unique case (ctrl.shift)
         SH_LEFT:          b_shift = {b_q[WORD_W-2:0], 1'b0};
         SH_RIGHT_LOGICAL: b_shift = {1'b0, b_q[WORD_W-1:1]};
         SH_RIGHT_ARITH:   b_shift = {b_q[WORD_W-1], b_q[WORD_W-1:1]};
         default:          b_shift = b_q;
      endcase
   end

   assign ain = ctrl.a_zero ? '0 : a_q;
   assign bin = ctrl.b_imm ? instr.sximm5 : b_shift;

   // Status is only loaded by CMP, so only the subtraction needs an overflow
   always_comb begin
      ovf = 1'b0;
      unique case (ctrl.alu_op)
         ALU_ADD: alu_out = ain + bin;
         ALU_CMP: begin
            alu_out = ain - bin;
            ovf = (ain[WORD_W-1] != bin[WORD_W-1]) && (alu_out[WORD_W-1] != ain[WORD_W-1]);
         end
         ALU_AND: alu_out = ain & bin;
         default: alu_out = ~bin;
      endcase
   end

   always_ff @(posedge clk) begin
      if (ctrl.load_status) begin
         status <= '{z: (alu_out == '0), n: alu_out[WORD_W-1], v: ovf};
      end
   end

   assign result = alu_out;

endmodule

`default_nettype wire

//--- verilog/sequencer.sv
// Control FSM with branch condition evaluation and all control outputs
`timescale 1ns/1ps
`default_nettype none

module sequencer (
   input  logic                    clk,
   input  logic                    reset,
   input  isa_pkg::decoded_instr_t instr,
   input  isa_pkg::status_t        status,
   dp_ctrl_if.ctrl                 dp,
   addr_ctrl_if.ctrl               ac,
   output logic                    load_ir,
   output ctrl_pkg::mem_cmd_t      mem_cmd,
   output logic                    halt
);
   import isa_pkg::*;
   import ctrl_pkg::*;

   state_t state;
   state_t next_state;
   logic   cond_true;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_RESET;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      unique case (instr.cond)
         COND_EQ: cond_true = status.z;
         COND_NE: cond_true = !status.z;
         COND_LT: cond_true = status.n != status.v;
         COND_LE: cond_true = status.z || (status.n != status.v);
         default: cond_true = 1'b1;
      endcase
   end

   always_comb begin
      next_state = ST_HALT;
      case (state)
         ST_RESET:     next_state = ST_FETCH;
         ST_FETCH:     next_state = ST_UPDATE_PC;
         ST_UPDATE_PC: next_state = ST_DECODE;
         ST_DECODE: begin
            case (instr.opcode)
               OPC_MOVE: begin
                  if (instr.op == 2'b10) begin
                     next_state = ST_MOV_IMM;
                  end else if (instr.op == 2'b00) begin
                     next_state = ST_MOV_REG;
                  end
               end
               OPC_ALU: begin
                  if (alu_op_t'(instr.op) == ALU_CMP) begin
                     next_state = ST_CMP;
                  end else begin
                     next_state = ST_ALU_WRITE;
                  end
               end
               OPC_LOAD, OPC_STORE: next_state = ST_ADDR_CALC;
               OPC_BRANCH: begin
                  // Condition codes above LE are not defined
                  if (instr.cond <= COND_LE) begin
                     next_state = ST_BRANCH;
                  end
               end
               default: next_state = ST_HALT;
            endcase
         end
         ST_ADDR_CALC: begin
            if (instr.opcode == OPC_LOAD) begin
               next_state = ST_LOAD_WB;
            end else begin
               next_state = ST_STORE;
            end
         end
         ST_MOV_IMM, ST_MOV_REG, ST_ALU_WRITE, ST_CMP,
         ST_LOAD_WB, ST_STORE, ST_BRANCH: next_state = ST_FETCH;
         default: next_state = ST_HALT;
      endcase
   end

   always_comb begin
      dp.read_a      = instr.rn;
      dp.read_b      = instr.rm;
      dp.write_num   = instr.rd;
      dp.write       = 1'b0;
      dp.load_status = 1'b0;
      dp.a_zero      = 1'b0;
      dp.b_imm       = 1'b0;
      dp.wb_sel      = WB_RESULT;
      dp.alu_op      = alu_op_t'(instr.op);
      dp.shift       = instr.shift;
      ac.load_pc     = 1'b0;
      ac.pc_sel      = PC_INCR;
      ac.load_addr   = 1'b0;
      ac.addr_from_pc = 1'b1;
      load_ir        = 1'b0;
      mem_cmd        = MEM_READ;
      halt           = 1'b0;

      // Memory states use the ALU as a plain adder
      if (state inside {ST_ADDR_CALC, ST_LOAD_WB, ST_STORE}) begin
         dp.alu_op = ALU_ADD;
         dp.shift  = SH_NONE;
      end

      case (state)
         ST_RESET: begin
            ac.load_pc = 1'b1;
            ac.pc_sel  = PC_ZERO;
         end
         ST_FETCH:     load_ir = 1'b1;
         ST_UPDATE_PC: ac.load_pc = 1'b1;
         ST_MOV_IMM: begin
            dp.write     = 1'b1;
            dp.write_num = instr.rn;
            dp.wb_sel    = WB_IMM8;
         end
         ST_MOV_REG: begin
            dp.a_zero = 1'b1;
            dp.write  = 1'b1;
         end
         ST_ALU_WRITE: dp.write = 1'b1;
         ST_CMP:       dp.load_status = 1'b1;
         ST_ADDR_CALC: begin
            // Fetch Rd into operand B for a following store
            dp.read_b       = instr.rd;
            dp.b_imm        = 1'b1;
            ac.load_addr    = 1'b1;
            ac.addr_from_pc = 1'b0;
         end
         ST_LOAD_WB: begin
            dp.write        = 1'b1;
            dp.wb_sel       = WB_MDATA;
            ac.addr_from_pc = 1'b0;
         end
         ST_STORE: begin
            dp.a_zero       = 1'b1;
            ac.addr_from_pc = 1'b0;
            mem_cmd         = MEM_WRITE;
         end
         ST_BRANCH: begin
            ac.load_pc = cond_true;
            ac.pc_sel  = PC_BRANCH;
         end
         ST_HALT: halt = 1'b1;
         default: halt = 1'b0;
      endcase
   end

   a_state_known: assert property (@(posedge clk) !reset |-> !$isunknown(state));

   // A write only follows the address calculation of a store instruction
   a_write_in_store: assert property (@(posedge clk)
      (mem_cmd == MEM_WRITE) |-> (instr.opcode == OPC_STORE) && $past(state == ST_ADDR_CALC));

   a_halt_sticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt);

endmodule

`default_nettype wire

//--- verilog/instr_decode.sv
// Instruction register and field decoder
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
   input  logic                    clk,
   input  logic                    load_ir,
   input  isa_pkg::word_t          read_data,
   output isa_pkg::decoded_instr_t instr
);
   import isa_pkg::*;

   word_t ir;

   always_ff @(posedge clk) begin
      if (load_ir) begin
         ir <= read_data;
      end
   end

   // Rn and cond share bits 10..8, imm8 overlaps Rd and the low fields
   always_comb begin
      instr.opcode = opcode_t'(ir[15:13]);
      instr.op     = ir[12:11];
      instr.rn     = ir[10:8];
      instr.rd     = ir[7:5];
      instr.shift  = shift_t'(ir[4:3]);
      instr.rm     = ir[2:0];
      instr.cond   = cond_t'(ir[10:8]);
      instr.sximm5 = {{(WORD_W-5){ir[4]}}, ir[4:0]};
      instr.sximm8 = {{(WORD_W-8){ir[7]}}, ir[7:0]};
   end

endmodule

`default_nettype wire

//--- verilog/cpu_ifs.sv
// Datapath control interface and address control interface with their modports
`timescale 1ns/1ps
`default_nettype none

interface dp_ctrl_if;
   import isa_pkg::*;
   import ctrl_pkg::*;

   reg_idx_t read_a;
   reg_idx_t read_b;
   reg_idx_t write_num;
   logic     write;
   logic     load_status;
   logic     a_zero;
   logic     b_imm;
   wb_sel_t  wb_sel;
   alu_op_t  alu_op;
   shift_t   shift;

   modport ctrl (output read_a, read_b, write_num, write, load_status,
                 a_zero, b_imm, wb_sel, alu_op, shift);
   modport dp (input read_a, read_b, write_num, write, load_status,
               a_zero, b_imm, wb_sel, alu_op, shift);
endinterface

interface addr_ctrl_if;
   import ctrl_pkg::*;

   logic    load_pc;
   pc_sel_t pc_sel;
   logic    load_addr;
   // High selects the PC onto the memory address, low the data address
   logic    addr_from_pc;

   modport ctrl (output load_pc, pc_sel, load_addr, addr_from_pc);
   modport addr (input load_pc, pc_sel, load_addr, addr_from_pc);
endinterface

`default_nettype wire

//--- verilog/ctrl_pkg.sv
// Machine control types: sequencer states, memory command, write-back source, next-PC select
`default_nettype none

package ctrl_pkg;

   typedef enum logic [3:0] {
      ST_RESET,
      ST_FETCH,
      ST_UPDATE_PC,
      ST_DECODE,
      ST_MOV_IMM,
      ST_MOV_REG,
      ST_ALU_WRITE,
      ST_CMP,
      ST_ADDR_CALC,
      ST_LOAD_WB,
      ST_STORE,
      ST_BRANCH,
      ST_HALT
   } state_t;

   typedef enum logic [1:0] {
      MEM_WRITE = 2'b00,
      MEM_READ  = 2'b01
   } mem_cmd_t;

   typedef enum logic [1:0] {
      WB_RESULT,
      WB_IMM8,
      WB_MDATA
   } wb_sel_t;

   typedef enum logic [1:0] {
      PC_ZERO,
      PC_INCR,
      PC_BRANCH
   } pc_sel_t;

endpackage

`default_nettype wire

//--- verilog/isa_pkg.sv
// Instruction set types: field widths, opcode, ALU, shift and condition enums, decoded instruction
`default_nettype none

package isa_pkg;

   localparam int WORD_W     = 16;
   localparam int REG_IDX_W  = 3;
   localparam int MEM_ADDR_W = 9;
   localparam int NUM_REGS   = 8;

   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [REG_IDX_W-1:0]  reg_idx_t;
   typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

   // 3'b010 and 3'b000 are left unassigned
   typedef enum logic [2:0] {
      OPC_BRANCH = 3'b001,
      OPC_LOAD   = 3'b011,
      OPC_STORE  = 3'b100,
      OPC_ALU    = 3'b101,
      OPC_MOVE   = 3'b110,
      OPC_HALT   = 3'b111
   } opcode_t;

   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_CMP = 2'b01,
      ALU_AND = 2'b10,
      ALU_MVN = 2'b11
   } alu_op_t;

   // One-bit shifts applied to operand B
   typedef enum logic [1:0] {
      SH_NONE          = 2'b00,
      SH_LEFT          = 2'b01,
      SH_RIGHT_LOGICAL = 2'b10,
      SH_RIGHT_ARITH   = 2'b11
   } shift_t;

   typedef enum logic [2:0] {
      COND_AL = 3'b000,
      COND_EQ = 3'b001,
      COND_NE = 3'b010,
      COND_LT = 3'b011,
      COND_LE = 3'b100
   } cond_t;

   typedef struct packed {
      logic z;
      logic n;
      logic v;
   } status_t;

   typedef struct packed {
      opcode_t    opcode;
      logic [1:0] op;
      reg_idx_t   rn;
      reg_idx_t   rd;
      reg_idx_t   rm;
      shift_t     shift;
      cond_t      cond;
      word_t      sximm5;
      word_t      sximm8;
   } decoded_instr_t;

endpackage

`default_nettype wire
